// File: Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/rv_core_pkg.sv
      - logic/apb_issue_port.sv
      - logic/ctrl_word.sv
      - logic/exec_unit.sv
      - logic/reg_file.sv
      - logic/rv_core_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/tb_rv_core.sv

// File: logic/apb_issue_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module apb_issue_port (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     psel,
    input  wire logic                     penable,
    input  wire logic                     pwrite,
    input  wire logic [`RV_APB_AW-1:0]    paddr,
    input  rv_core_pkg::word_t            pwdata,
    output rv_core_pkg::word_t            prdata,
    output logic                          pready,
    output logic                          pslverr,
    output rv_core_pkg::rv32i_opcode      opcode,
    output logic [2:0]                    funct3,
    output logic [6:0]                    funct7,
    output rv_core_pkg::reg_idx_t         rd_idx,
    output rv_core_pkg::reg_idx_t         rs1_idx,
    output rv_core_pkg::reg_idx_t         rs2_idx,
    input  rv_core_pkg::ctrlex_t          ctrlex,
    input  rv_core_pkg::ctrlwb_t          ctrlwb,
    input  wire logic                     illegal,
    output rv_core_pkg::issue_t           issue,
    input  rv_core_pkg::word_t            pc_next,
    input  wire logic                     pc_load,
    output rv_core_pkg::reg_idx_t         rb_idx,
    input  rv_core_pkg::word_t            rb_val
);
    import rv_core_pkg::*;

    logic    access;
    logic    hit_instr;
    logic    hit_pc;
    logic    hit_reg;
    logic    issue_go;
    word_t   pc_q;
    logic    issue_valid_q;
    word_t   issue_pc_q;
    ctrlex_t issue_ctrlex_q;
    ctrlwb_t issue_ctrlwb_q;
    imm_t    issue_imm_q;
    imm_t    imm;

    assign access    = psel & penable;
    assign hit_instr = (paddr == `RV_ADDR_INSTR);
    assign hit_pc    = (paddr == `RV_ADDR_PC);
    assign hit_reg   = ((paddr & ~`RV_ADDR_REG_MASK) == `RV_ADDR_REG_BASE);
    assign issue_go  = access & pwrite & hit_instr & ~illegal;

    // instruction fields straight off the write data.
    assign opcode  = rv32i_opcode'(pwdata[6:0]);
    assign funct3  = pwdata[14:12];
    assign funct7  = pwdata[31:25];
    assign rd_idx  = pwdata[11:7];
    assign rs1_idx = pwdata[19:15];
    assign rs2_idx = pwdata[24:20];

    assign imm.i = {{21{pwdata[31]}}, pwdata[30:20]};
    assign imm.s = {{21{pwdata[31]}}, pwdata[30:25], pwdata[11:7]};
    assign imm.b = {{20{pwdata[31]}}, pwdata[7], pwdata[30:25], pwdata[11:8], 1'b0};
    assign imm.u = {pwdata[31:12], 12'h000};
    assign imm.j = {{12{pwdata[31]}}, pwdata[19:12], pwdata[20], pwdata[30:21], 1'b0};

    assign pready = 1'b1; // every instruction retires before the next access.
    assign rb_idx = paddr[6:2];

    always_comb begin
        prdata  = '0;
        pslverr = 1'b0;
        if (access) begin
            if (pwrite) begin
                pslverr = ~(hit_pc | (hit_instr & ~illegal));
            end else if (hit_pc) begin
                prdata = pc_q;
            end else if (hit_reg) begin
                prdata = rb_val;
            end else begin
                pslverr = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q          <= '0;
            issue_valid_q <= 1'b0;
        end else begin
            issue_valid_q <= issue_go; // single cycle, execute drains it at e+1.
            if (pc_load) begin
                pc_q <= pc_next;
            end else if (access && pwrite && hit_pc) begin
                pc_q <= pwdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_go) begin
            issue_pc_q     <= pc_q;
            issue_ctrlex_q <= ctrlex;
            issue_ctrlwb_q <= ctrlwb;
            issue_imm_q    <= imm;
        end
    end

    assign issue = '{valid: issue_valid_q, pc: issue_pc_q, ctrlex: issue_ctrlex_q,
                     ctrlwb: issue_ctrlwb_q, imm: issue_imm_q};

endmodule : apb_issue_port

`default_nettype wire

// File: logic/ctrl_word.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_word (
    input  rv_core_pkg::rv32i_opcode opcode,
    input  wire logic [2:0]          funct3,
    input  wire logic [6:0]          funct7,
    input  rv_core_pkg::reg_idx_t    rd_in,
    input  rv_core_pkg::reg_idx_t    rs1_in,
    input  rv_core_pkg::reg_idx_t    rs2_in,
    output rv_core_pkg::ctrlex_t     ctrlex,
    output rv_core_pkg::ctrlwb_t     ctrlwb,
    output logic                     illegal
);
    import rv_core_pkg::*;

    arith_funct3_t arith_funct3;

    assign arith_funct3 = arith_funct3_t'(funct3);

    always_comb begin
        ctrlex.pcmux_sel      = pcmux_pc_plus4;
        ctrlex.alumux1_sel    = alumux1_rs1_out;
        ctrlex.alumux2_sel    = alumux2_i_imm;
        ctrlex.aluop          = alu_add;
        ctrlex.cmpmux_sel     = cmpmux_rs2_out;
        ctrlex.cmpop          = branch_funct3_t'(funct3);
        ctrlex.is_branch      = 1'b0;
        ctrlwb.load_regfile   = 1'b0;
        ctrlwb.regfilemux_sel = regfilemux_alu_out;
        ctrlwb.rd             = rd_in;
        ctrlwb.rs1            = rs1_in;
        ctrlwb.rs2            = rs2_in;
        illegal               = 1'b0;

        case (opcode)
            op_lui: begin
                ctrlwb.load_regfile   = 1'b1;
                ctrlwb.regfilemux_sel = regfilemux_u_imm;
            end

            op_auipc: begin
                ctrlex.alumux1_sel  = alumux1_pc_out;
                ctrlex.alumux2_sel  = alumux2_u_imm;
                ctrlwb.load_regfile = 1'b1;
            end

            op_imm: begin
                ctrlwb.load_regfile = 1'b1;
                case (arith_funct3)
                    slt: begin
                        ctrlwb.regfilemux_sel = regfilemux_br_en;
                        ctrlex.cmpmux_sel     = cmpmux_i_imm;
                        ctrlex.cmpop          = blt;
                    end
                    sltu: begin
                        ctrlwb.regfilemux_sel = regfilemux_br_en;
                        ctrlex.cmpmux_sel     = cmpmux_i_imm;
                        ctrlex.cmpop          = bltu;
                    end
                    sr: begin
                        ctrlex.aluop = funct7[5] ? alu_sra : alu_srl;
                    end
                    default: begin
                        ctrlex.aluop = alu_ops'(funct3);
                    end
                endcase
            end

            op_reg: begin
                ctrlwb.load_regfile = 1'b1;
                ctrlex.alumux2_sel  = alumux2_rs2_out;
                case (arith_funct3)
                    add: begin
                        ctrlex.aluop = funct7[5] ? alu_sub : alu_add;
                    end
                    slt: begin
                        ctrlwb.regfilemux_sel = regfilemux_br_en;
                        ctrlex.cmpop          = blt;
                    end
                    sltu: begin
                        ctrlwb.regfilemux_sel = regfilemux_br_en;
                        ctrlex.cmpop          = bltu;
                    end
                    sr: begin
                        ctrlex.aluop = funct7[5] ? alu_sra : alu_srl;
                    end
                    default: begin
                        ctrlex.aluop = alu_ops'(funct3);
                    end
                endcase
            end

            op_jal: begin
                ctrlex.alumux1_sel    = alumux1_pc_out;
                ctrlex.alumux2_sel    = alumux2_j_imm;
                ctrlex.pcmux_sel      = pcmux_alu_out;
                ctrlwb.load_regfile   = 1'b1;
                ctrlwb.regfilemux_sel = regfilemux_pc_plus4;
            end

            op_jalr: begin
                ctrlex.pcmux_sel      = pcmux_alu_mod2; // target lsb forced to zero.
                ctrlwb.load_regfile   = 1'b1;
                ctrlwb.regfilemux_sel = regfilemux_pc_plus4;
            end

            op_br: begin
                ctrlex.alumux1_sel = alumux1_pc_out;
                ctrlex.alumux2_sel = alumux2_b_imm;
                ctrlex.is_branch   = 1'b1;
            end

            default: begin
                illegal = 1'b1; // load, store and anything unknown.
            end
        endcase
    end

endmodule : ctrl_word

`default_nettype wire

// File: logic/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  rv_core_pkg::issue_t issue,
    input  rv_core_pkg::word_t  rs1_val,
    input  rv_core_pkg::word_t  rs2_val,
    output rv_core_pkg::wb_t    wb,
    output rv_core_pkg::word_t  pc_next,
    output logic                pc_load
);
    import rv_core_pkg::*;

    word_t      alu_a;
    word_t      alu_b;
    word_t      alu_res;
    word_t      cmp_b;
    word_t      pc_plus4;
    logic       br_en;
    logic [4:0] shamt;

    assign pc_plus4 = issue.pc + 32'd4;
    assign alu_a    = (issue.ctrlex.alumux1_sel == alumux1_pc_out) ? issue.pc : rs1_val;
    assign cmp_b    = (issue.ctrlex.cmpmux_sel == cmpmux_i_imm) ? issue.imm.i : rs2_val;
    assign shamt    = alu_b[4:0];

    always_comb begin
        case (issue.ctrlex.alumux2_sel)
            alumux2_u_imm:   alu_b = issue.imm.u;
            alumux2_b_imm:   alu_b = issue.imm.b;
            alumux2_s_imm:   alu_b = issue.imm.s;
            alumux2_j_imm:   alu_b = issue.imm.j;
            alumux2_rs2_out: alu_b = rs2_val;
            default:         alu_b = issue.imm.i;
        endcase
    end

    always_comb begin
        case (issue.ctrlex.aluop)
            alu_sll: alu_res = alu_a << shamt;
            alu_sra: alu_res = word_t'($signed(alu_a) >>> shamt);
            alu_sub: alu_res = alu_a - alu_b;
            alu_xor: alu_res = alu_a ^ alu_b;
            alu_srl: alu_res = alu_a >> shamt;
            alu_or:  alu_res = alu_a | alu_b;
            alu_and: alu_res = alu_a & alu_b;
            default: alu_res = alu_a + alu_b;
        endcase
    end

    always_comb begin
        case (issue.ctrlex.cmpop)
            beq:     br_en = (rs1_val == cmp_b);
            bne:     br_en = (rs1_val != cmp_b);
            blt:     br_en = ($signed(rs1_val) < $signed(cmp_b));
            bge:     br_en = ($signed(rs1_val) >= $signed(cmp_b));
            bltu:    br_en = (rs1_val < cmp_b);
            bgeu:    br_en = (rs1_val >= cmp_b);
            default: br_en = 1'b0;
        endcase
    end

    always_comb begin
        case (issue.ctrlex.pcmux_sel)
            pcmux_alu_out:  pc_next = alu_res;
            pcmux_alu_mod2: pc_next = {alu_res[31:1], 1'b0};
            default:        pc_next = (issue.ctrlex.is_branch && br_en) ? alu_res : pc_plus4;
        endcase
    end

    always_comb begin
        wb.we = issue.valid & issue.ctrlwb.load_regfile;
        wb.rd = issue.ctrlwb.rd;
        case (issue.ctrlwb.regfilemux_sel)
            regfilemux_br_en:    wb.data = {31'b0, br_en};
            regfilemux_u_imm:    wb.data = issue.imm.u;
            regfilemux_pc_plus4: wb.data = pc_plus4; // link address.
            default:             wb.data = alu_res;
        endcase
    end

    assign pc_load = issue.valid;

endmodule : exec_unit

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  rv_core_pkg::wb_t     wb,
    input  rv_core_pkg::reg_idx_t rs1_idx,
    input  rv_core_pkg::reg_idx_t rs2_idx,
    input  rv_core_pkg::reg_idx_t rb_idx,
    output rv_core_pkg::word_t   rs1_val,
    output rv_core_pkg::word_t   rs2_val,
    output rv_core_pkg::word_t   rb_val
);
    import rv_core_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.data; // x0 is never written, so it stays zero.
        end
    end

    assign rs1_val = regs[rs1_idx];
    assign rs2_val = regs[rs2_idx];
    assign rb_val  = regs[rb_idx];

endmodule : reg_file

`default_nettype wire

// File: logic/rv_core_config.svh
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// APB address width.
`define RV_APB_AW 8

// register map.
`define RV_ADDR_INSTR    8'h00
`define RV_ADDR_PC       8'h04
`define RV_ADDR_REG_BASE 8'h80

// index bits of a register address, paddr[6:2].
`define RV_ADDR_REG_MASK 8'h7c

`endif

// File: logic/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    typedef enum logic [2:0] {
        add, sll, slt, sltu, axor, sr, aor, aand
    } arith_funct3_t;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    // same order as funct3, so add, sll, xor, or and and map directly.
    typedef enum logic [2:0] {
        alu_add, alu_sll, alu_sra, alu_sub, alu_xor, alu_srl, alu_or, alu_and
    } alu_ops;

    typedef enum logic [1:0] {pcmux_pc_plus4, pcmux_alu_out, pcmux_alu_mod2} pcmux_sel_t;
    typedef enum logic {alumux1_rs1_out, alumux1_pc_out} alumux1_sel_t;
    typedef enum logic [2:0] {
        alumux2_i_imm, alumux2_u_imm, alumux2_b_imm, alumux2_s_imm, alumux2_j_imm,
        alumux2_rs2_out
    } alumux2_sel_t;
    typedef enum logic {cmpmux_rs2_out, cmpmux_i_imm} cmpmux_sel_t;
    typedef enum logic [1:0] {
        regfilemux_alu_out, regfilemux_br_en, regfilemux_u_imm, regfilemux_pc_plus4
    } regfilemux_sel_t;

    typedef struct packed {
        pcmux_sel_t     pcmux_sel;
        alumux1_sel_t   alumux1_sel;
        alumux2_sel_t   alumux2_sel;
        alu_ops         aluop;
        cmpmux_sel_t    cmpmux_sel;
        branch_funct3_t cmpop;
        logic           is_branch;
    } ctrlex_t;

    typedef struct packed {
        logic            load_regfile;
        regfilemux_sel_t regfilemux_sel;
        reg_idx_t        rd;
        reg_idx_t        rs1;
        reg_idx_t        rs2;
    } ctrlwb_t;

    typedef struct packed {
        word_t i;
        word_t s;
        word_t b;
        word_t u;
        word_t j;
    } imm_t;

    typedef struct packed {
        logic    valid;
        word_t   pc;
        ctrlex_t ctrlex;
        ctrlwb_t ctrlwb;
        imm_t    imm;
    } issue_t;

    typedef struct packed {
        logic     we;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

endpackage : rv_core_pkg

`default_nettype wire

// File: logic/rv_core_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module rv_core_top (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  psel,
    input  wire logic                  penable,
    input  wire logic                  pwrite,
    input  wire logic [`RV_APB_AW-1:0] paddr,
    input  rv_core_pkg::word_t         pwdata,
    output rv_core_pkg::word_t         prdata,
    output logic                       pready,
    output logic                       pslverr
);
    import rv_core_pkg::*;

    rv32i_opcode opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    reg_idx_t    rd_idx;
    reg_idx_t    rs1_idx;
    reg_idx_t    rs2_idx;
    ctrlex_t     ctrlex;
    ctrlwb_t     ctrlwb;
    logic        illegal;
    issue_t      issue;
    word_t       pc_next;
    logic        pc_load;
    reg_idx_t    rb_idx;
    word_t       rb_val;
    word_t       rs1_val;
    word_t       rs2_val;
    wb_t         wb;

    apb_issue_port u_issue_port (
        .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
        .opcode, .funct3, .funct7, .rd_idx, .rs1_idx, .rs2_idx,
        .ctrlex, .ctrlwb, .illegal, .issue, .pc_next, .pc_load, .rb_idx, .rb_val
    );

    ctrl_word u_ctrl_word (
        .opcode, .funct3, .funct7,
        .rd_in(rd_idx), .rs1_in(rs1_idx), .rs2_in(rs2_idx),
        .ctrlex, .ctrlwb, .illegal
    );

    exec_unit u_exec_unit (
        .issue, .rs1_val, .rs2_val, .wb, .pc_next, .pc_load
    );

    // operand ports follow the stored indices, readback follows paddr.
    reg_file u_reg_file (
        .clk, .rst_n, .wb,
        .rs1_idx(issue.ctrlwb.rs1), .rs2_idx(issue.ctrlwb.rs2), .rb_idx,
        .rs1_val, .rs2_val, .rb_val
    );

endmodule : rv_core_top

`default_nettype wire

// File: sim.f
+incdir+logic
logic/rv_core_pkg.sv
logic/apb_issue_port.sv
logic/ctrl_word.sv
logic/exec_unit.sv
logic/reg_file.sv
logic/rv_core_top.sv
verif/tb_rv_core.sv

// File: verif/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_config.svh"

module tb_rv_core;
    import rv_core_pkg::*;

    localparam int timeout_cycles = 20000; // about six times the test length.

    logic                  clk;
    logic                  rst_n;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [`RV_APB_AW-1:0] paddr;
    word_t                 pwdata;
    word_t                 prdata;
    logic                  pready;
    logic                  pslverr;
    word_t                 model_regs [32];
    word_t                 model_pc;
    int                    cycles = 0;

    rv_core_top u_dut (
        .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
            $display("Test failures found");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string name, input word_t exp, input word_t act);
        assert (act === exp) else begin
            $display("ERROR: %s expected 0x%08h actual 0x%08h", name, exp, act);
            $display("Test failures found");
            $fatal(1, "mismatch");
        end
    endtask

    // one apb transfer, sampled in the middle of the access phase.
    task automatic apb_xfer(input logic write, input logic [`RV_APB_AW-1:0] addr,
                            input word_t wdata, output word_t rdata, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #1;
        rdata = prdata;
        err   = pslverr;
        check_value("pready", 32'd1, {31'b0, pready});
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    function automatic logic [`RV_APB_AW-1:0] reg_addr(input reg_idx_t idx);
        return `RV_ADDR_REG_BASE + {idx, 2'b00};
    endfunction

    function automatic word_t encode(input rv32i_opcode opc, input logic [2:0] f3,
                                     input logic alt, input reg_idx_t rd, input reg_idx_t rs1,
                                     input reg_idx_t rs2, input word_t imm);
        case (opc)
            op_lui, op_auipc: return {imm[31:12], rd, opc};
            op_jal:           return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc};
            op_br:            return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc};
            op_reg:           return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, opc};
            default: begin
                if (opc == op_imm && (f3 == 3'd1 || f3 == 3'd5)) begin
                    return {1'b0, alt, 5'b0, imm[4:0], rs1, f3, rd, opc};
                end
                return {imm[11:0], rs1, f3, rd, opc};
            end
        endcase
    endfunction

    function automatic word_t alu_ref(input logic [2:0] f3, input logic is_sub,
                                      input logic is_sra, input word_t a, input word_t b);
        case (f3)
            3'd0:    return is_sub ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return is_sra ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    // issue one instruction, advance the model, then read back pc and rd.
    task automatic run_instr(input rv32i_opcode opc, input logic [2:0] f3, input logic alt,
                             input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2,
                             input word_t imm);
        word_t a;
        word_t b;
        word_t res;
        word_t pc4;
        word_t data;
        logic  err;
        a   = model_regs[rs1];
        b   = (opc == op_reg || opc == op_br) ? model_regs[rs2] : imm;
        pc4 = model_pc + 32'd4;
        res = pc4; // link value for jal and jalr.
        apb_xfer(1'b1, `RV_ADDR_INSTR, encode(opc, f3, alt, rd, rs1, rs2, imm), data, err);
        check_value("pslverr", 32'd0, {31'b0, err});
        case (opc)
            op_lui:   res = imm;
            op_auipc: res = model_pc + imm;
            op_jal:   model_pc = model_pc + imm;
            op_jalr:  model_pc = (a + imm) & ~32'd1;
            op_br:    model_pc = branch_ref(f3, a, b) ? model_pc + imm : pc4;
            default:  res = alu_ref(f3, alt && (opc == op_reg), alt, a, b);
        endcase
        if (opc != op_jal && opc != op_jalr && opc != op_br) begin
            model_pc = pc4;
        end
        if (opc != op_br && rd != 5'd0) begin
            model_regs[rd] = res;
        end
        apb_xfer(1'b0, `RV_ADDR_PC, '0, data, err);
        check_value("pc", model_pc, data);
        apb_xfer(1'b0, reg_addr(rd), '0, data, err);
        check_value($sformatf("x%0d", rd), model_regs[rd], data);
    endtask

    task automatic check_state();
        word_t data;
        logic  err;
        apb_xfer(1'b0, `RV_ADDR_PC, '0, data, err);
        check_value("pc", model_pc, data);
        check_value("pslverr", 32'd0, {31'b0, err});
        for (int i = 0; i < 32; i++) begin
            apb_xfer(1'b0, reg_addr(reg_idx_t'(i)), '0, data, err);
            check_value($sformatf("x%0d", i), model_regs[i], data);
            check_value("pslverr", 32'd0, {31'b0, err});
        end
    endtask

    task automatic test_arith(input int count);
        word_t      r;
        logic [2:0] f3;
        word_t      imm;
        for (int i = 0; i < count; i++) begin
            r   = $urandom;
            f3  = 3'($urandom);
            imm = (f3 == 3'd1 || f3 == 3'd5) ? {27'b0, r[4:0]} : {{20{r[11]}}, r[11:0]};
            case ($urandom_range(3, 0))
                0: run_instr(op_lui, 3'd0, 1'b0, reg_idx_t'($urandom), 5'd0, 5'd0,
                             {r[31:12], 12'h000});
                1: run_instr(op_auipc, 3'd0, 1'b0, reg_idx_t'($urandom), 5'd0, 5'd0,
                             {r[31:12], 12'h000});
                2: run_instr(op_imm, f3, r[30] & (f3 == 3'd5), reg_idx_t'($urandom),
                             reg_idx_t'($urandom), 5'd0, imm);
                default: begin
                    run_instr(op_reg, f3, r[30] & (f3 == 3'd0 || f3 == 3'd5),
                              (i % 8 == 0) ? 5'd0 : reg_idx_t'($urandom),
                              reg_idx_t'($urandom), reg_idx_t'($urandom), '0);
                end
            endcase
        end
    endtask

    task automatic test_control(input int count);
        word_t          r;
        reg_idx_t       rs1;
        word_t          data;
        logic           err;
        logic [2:0]     f3_list [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        // jumps start from a host-written pc.
        r = $urandom;
        apb_xfer(1'b1, `RV_ADDR_PC, {r[31:2], 2'b00}, data, err);
        check_value("pslverr", 32'd0, {31'b0, err});
        model_pc = {r[31:2], 2'b00};
        for (int i = 0; i < count; i++) begin
            r = $urandom;
            run_instr(op_jal, 3'd0, 1'b0, reg_idx_t'($urandom), 5'd0, 5'd0,
                      {{11{r[20]}}, r[20:1], 1'b0});
            run_instr(op_jalr, 3'd0, 1'b0, reg_idx_t'($urandom), reg_idx_t'($urandom), 5'd0,
                      {{20{r[11]}}, r[11:0]});
        end
        foreach (f3_list[k]) begin
            for (int i = 0; i < count; i++) begin
                r   = $urandom;
                rs1 = reg_idx_t'($urandom);
                // equal operands on the first pass, random ones after.
                run_instr(op_br, f3_list[k], 1'b0, 5'd0, rs1,
                          (i == 0) ? rs1 : reg_idx_t'($urandom), {{19{r[12]}}, r[12:1], 1'b0});
            end
        end
    endtask

    task automatic test_errors();
        word_t data;
        logic  err;
        word_t bad_words [3] = '{{12'h123, 5'd1, 3'b010, 5'd2, op_load},
                                 {7'h00, 5'd3, 5'd4, 3'b010, 5'd5, op_store}, 32'hffff_ffff};
        foreach (bad_words[k]) begin
            apb_xfer(1'b1, `RV_ADDR_INSTR, bad_words[k], data, err);
            check_value("pslverr", 32'd1, {31'b0, err});
        end
        apb_xfer(1'b1, 8'h08, 32'h1234_5678, data, err);
        check_value("pslverr", 32'd1, {31'b0, err});
        apb_xfer(1'b1, reg_addr(5'd1), 32'hdead_beef, data, err);
        check_value("pslverr", 32'd1, {31'b0, err});
        apb_xfer(1'b0, 8'h10, '0, data, err);
        check_value("pslverr", 32'd1, {31'b0, err});
        check_value("prdata", 32'd0, data);
    endtask

    initial begin
        clk     = 1'b0;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        void'($urandom(24325));
        model_pc = '0;
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_state();
        test_arith(300);
        check_state();
        test_control(6);
        test_errors();
        check_state();
        $display("All tests passed!");
        $finish;
    end

endmodule : tb_rv_core

`default_nettype wire
